/* flist.f */
rtl/datapath_pkg.sv
rtl/field_ctl_pkg.sv
rtl/word_rotator.sv
rtl/field_mask_gen.sv
rtl/field_ctl_reg.sv
rtl/result_merge.sv
rtl/byte_field_unit.sv
verification/byte_field_unit_tb.sv

/* rtl/byte_field_unit.sv */
// byte-field unit top; rotate, load byte and deposit byte on 32-bit words with one cycle latency.

`timescale 1ns/1ps

module byte_field_unit (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      ctl_load,
   input  field_ctl_pkg::field_ctl_t ctl,
   input  logic                      start,
   input  datapath_pkg::word_t       m,
   input  datapath_pkg::word_t       a,
   output datapath_pkg::word_t       result,
   output logic                      result_valid
);

   import datapath_pkg::*;
   import field_ctl_pkg::*;

   field_drv_t drv;                     // derived field control.
   word_t      rotated;
   word_t      mask;

   // **************************************************
   // control
   // **************************************************

   field_ctl_reg u_field_ctl_reg (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctl_load (ctl_load),
      .ctl      (ctl),
      .drv      (drv)
   );

   // **************************************************
   // datapath
   // **************************************************

   word_rotator u_word_rotator (
      .m       (m),
      .amt     (drv.rot_amt),
      .rotated (rotated)
   );

   field_mask_gen u_field_mask_gen (
      .left  (drv.mask_left),
      .right (drv.mask_right),
      .mask  (mask)
   );

   result_merge u_result_merge (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .rotated      (rotated),
      .mask         (mask),
      .a            (a),
      .keep_a       (drv.keep_a),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

/* rtl/datapath_pkg.sv */
// datapath word width and index types shared by the byte-field blocks; import where words are handled.

package datapath_pkg;

   // **************************************************
   // widths
   // **************************************************

   localparam int WORD_BITS = 32;                        // datapath width.
   localparam int POS_BITS  = $clog2(WORD_BITS);         // bits in a bit index.

   // **************************************************
   // types
   // **************************************************

   // one datapath word, memory operand or second operand.
   typedef logic [WORD_BITS-1:0] word_t;

   // bit index for position, length, rotate amount and mask bounds.
   typedef logic [POS_BITS-1:0] bit_idx_t;

   localparam bit_idx_t MSB_IDX = bit_idx_t'(WORD_BITS - 1);   // top bit of a word.

endpackage

/* rtl/field_ctl_pkg.sv */
// field operation codes and control structs for the byte-field unit; import in control and top.

package field_ctl_pkg;

   // **************************************************
   // operation codes
   // **************************************************

   typedef enum logic [1:0] {
      FOP_ROTATE = 2'd0,                // rotate left by pos.
      FOP_LDB    = 2'd1,                // load byte, right-justified.
      FOP_DPB    = 2'd2                 // deposit byte into a.
   } field_op_e;

   // **************************************************
   // control words
   // **************************************************

   // field control as loaded from the microword.
   typedef struct packed {
      field_op_e              op;
      datapath_pkg::bit_idx_t pos;      // field position, lsb index.
      datapath_pkg::bit_idx_t len;      // field length minus one.
   } field_ctl_t;

   // controls derived from field_ctl_t, held in the control register
   typedef struct packed {
      datapath_pkg::bit_idx_t rot_amt;      // left rotate of m.
      datapath_pkg::bit_idx_t mask_left;    // highest mask bit.
      datapath_pkg::bit_idx_t mask_right;   // lowest mask bit.
      logic                   keep_a;       // a fills bits outside the mask.
   } field_drv_t;

   // rotate by 0 over the full word, i.e. ROTATE with pos 0 and len 31.
   localparam field_drv_t DRV_RESET = '{
      rot_amt:    '0,
      mask_left:  datapath_pkg::MSB_IDX,
      mask_right: '0,
      keep_a:     1'b0
   };

endpackage

/* rtl/field_ctl_reg.sv */
// field control register; latches op, pos and len on a strobe and holds the derived datapath controls.

`timescale 1ns/1ps

module field_ctl_reg (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     ctl_load,
   input  field_ctl_pkg::field_ctl_t ctl,
   output field_ctl_pkg::field_drv_t drv
);

   import datapath_pkg::*;
   import field_ctl_pkg::*;

   logic [POS_BITS:0] dpb_end;          // pos + len, one bit wider.
   field_drv_t        drv_next;

   // **************************************************
   // derive rotate amount and mask bounds
   // **************************************************

   assign dpb_end = {1'b0, ctl.pos} + {1'b0, ctl.len};

   always_comb begin
      drv_next.rot_amt    = ctl.pos;
      drv_next.mask_left  = MSB_IDX;
      drv_next.mask_right = '0;
      drv_next.keep_a     = 1'b0;
      case (ctl.op)
         FOP_LDB: begin
            // rotate right by pos, so the field lands at bit 0.
            drv_next.rot_amt   = bit_idx_t'(WORD_BITS - int'(ctl.pos));
            drv_next.mask_left = ctl.len;
         end
         FOP_DPB: begin
            drv_next.mask_right = ctl.pos;
            drv_next.keep_a     = 1'b1;
            if (dpb_end > MSB_IDX) begin
               drv_next.mask_left = MSB_IDX;        // field runs off the top.
            end else begin
               drv_next.mask_left = dpb_end[POS_BITS-1:0];
            end
         end
         default: ;                     // rotate, full word.
      endcase
   end

   // **************************************************
   // control register
   // **************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         drv <= DRV_RESET;
      end else if (ctl_load) begin
         drv <= drv_next;
      end
   end

   // the merge stage relies on a non-empty mask for every op.
   a_mask_order: assert property (
      @(posedge clk) disable iff (!rst_n)
      drv.mask_right <= drv.mask_left
   );

endmodule

/* rtl/field_mask_gen.sv */
// builds a contiguous bit mask between two bit indices; drives the merge stage select.

`timescale 1ns/1ps

module field_mask_gen (
   input  datapath_pkg::bit_idx_t left,
   input  datapath_pkg::bit_idx_t right,
   output datapath_pkg::word_t    mask
);

   import datapath_pkg::*;

   // **************************************************
   // mask decode
   // **************************************************

   // a bit is set when right <= index <= left.
   always_comb begin
      for (int i = 0; i < WORD_BITS; i++) begin
         mask[i] = (bit_idx_t'(i) >= right) && (bit_idx_t'(i) <= left);
      end
   end

endmodule

/* rtl/result_merge.sv */
// merges the rotated word with the second operand under the field mask and registers the result.

`timescale 1ns/1ps

module result_merge (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                start,
   input  datapath_pkg::word_t rotated,
   input  datapath_pkg::word_t mask,
   input  datapath_pkg::word_t a,
   input  logic                keep_a,
   output datapath_pkg::word_t result,
   output logic                result_valid
);

   import datapath_pkg::*;

   word_t fill;                         // bits outside the field.
   word_t merged;

   // **************************************************
   // merge
   // **************************************************

   assign fill   = keep_a ? (a & ~mask) : '0;
   assign merged = (rotated & mask) | fill;

   // **************************************************
   // result register
   // **************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result       <= '0;
         result_valid <= 1'b0;
      end else begin
         result_valid <= start;         // one pulse per start.
         if (start) begin
            result <= merged;
         end
      end
   end

   // a started merge always takes at least one bit from the rotated word.
   a_mask_present: assert property (
      @(posedge clk) disable iff (!rst_n)
      start |-> (mask != '0)
   );

endmodule

/* rtl/word_rotator.sv */
// combinational 32-bit left rotator in two levels; feeds the merge stage of the byte-field unit.

`timescale 1ns/1ps

module word_rotator (
   input  datapath_pkg::word_t    m,
   input  datapath_pkg::bit_idx_t amt,
   output datapath_pkg::word_t    rotated
);

   import datapath_pkg::*;

   word_t sa;                           // after the fine level.

   // **************************************************
   // level 1, rotate by 0 to 3
   // **************************************************

   always_comb begin
      case (amt[1:0])
         2'd0:    sa = m;
         2'd1:    sa = {m[30:0], m[31]};
         2'd2:    sa = {m[29:0], m[31:30]};
         default: sa = {m[28:0], m[31:29]};
      endcase
   end

   // **************************************************
   // level 2, rotate in steps of 4
   // **************************************************

   always_comb begin
      case (amt[4:2])
         3'd0:    rotated = sa;
         3'd1:    rotated = {sa[27:0], sa[31:28]};       // by 4.
         3'd2:    rotated = {sa[23:0], sa[31:24]};       // by 8.
         3'd3:    rotated = {sa[19:0], sa[31:20]};       // by 12.
         3'd4:    rotated = {sa[15:0], sa[31:16]};       // by 16.
         3'd5:    rotated = {sa[11:0], sa[31:12]};       // by 20.
         3'd6:    rotated = {sa[7:0], sa[31:8]};         // by 24.
         default: rotated = {sa[3:0], sa[31:4]};         // by 28.
      endcase
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the byte-field unit testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
   verilator --binary --timing --assert -f flist.f \
      --top-module byte_field_unit_tb -o byte_field_unit_sim ||
   { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/byte_field_unit_sim)"
echo "$sim_out"

echo "$sim_out" | grep -q "SIMULATION PASSED" &&
   exit 0 ||
   exit 1

/* verification/byte_field_unit_tb.sv */
// testbench for the byte-field unit; applies a table of rotate, LDB and DPB operations and checks results.

`timescale 1ns/1ps

module byte_field_unit_tb;

   import datapath_pkg::*;
   import field_ctl_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int NUM_ROWS    = 120;
   localparam int WATCHDOG_NS = (NUM_ROWS + 20) * CLK_PERIOD * 4;
   localparam logic [31:0] SEED = 32'h50f37d40;

   // one table row, control plus operands and the expected result.
   typedef struct packed {
      field_ctl_t ctl;
      word_t      m;
      word_t      a;
      word_t      want;
   } row_t;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       ctl_load;
   field_ctl_t ctl;
   logic       start;
   word_t      m;
   word_t      a;
   word_t      result;
   logic       result_valid;

   row_t rows [NUM_ROWS];
   int   n_rows   = 0;
   int   n_checks = 0;
   int   n_errors = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   byte_field_unit DUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctl_load     (ctl_load),
      .ctl          (ctl),
      .start        (start),
      .m            (m),
      .a            (a),
      .result       (result),
      .result_valid (result_valid)
   );

   // **************************************************
   // reference model and table helpers
   // **************************************************

   function automatic word_t field_result_model(input field_ctl_t c, input word_t mw,
                                                input word_t aw);
      logic [63:0] dbl;
      logic [63:0] shl;
      logic [63:0] shr;
      logic [63:0] fmask;
      int          hi;
      word_t       res;
      dbl = {mw, mw};
      shl = dbl << c.pos;
      shr = dbl >> c.pos;
      case (c.op)
         FOP_ROTATE: res = shl[63:32];              // rotate left by pos.
         FOP_LDB: begin
            fmask = (64'd1 << (int'(c.len) + 1)) - 64'd1;
            res   = shr[31:0] & fmask[31:0];        // field down to bit 0.
         end
         FOP_DPB: begin
            hi = int'(c.pos) + int'(c.len);
            if (hi > 31) begin
               hi = 31;                             // field stops at the top bit.
            end
            fmask = ((64'd1 << (hi + 1)) - 64'd1) & ~((64'd1 << c.pos) - 64'd1);
            res   = ((mw << c.pos) & fmask[31:0]) | (aw & ~fmask[31:0]);
         end
         default: res = '0;
      endcase
      return res;
   endfunction

   function automatic field_ctl_t make_ctl(input field_op_e op, input int pos, input int len);
      field_ctl_t c;
      c.op  = op;
      c.pos = bit_idx_t'(pos);
      c.len = bit_idx_t'(len);                      // length minus one.
      return c;
   endfunction

   task automatic add_row(input field_ctl_t c, input word_t mw, input word_t aw,
                          input word_t want);
      rows[n_rows] = '{ctl: c, m: mw, a: aw, want: want};
      n_rows++;
   endtask

   task automatic add_random_row(input field_op_e op);
      field_ctl_t c;
      word_t      mw;
      word_t      aw;
      c  = make_ctl(op, int'($urandom % 32), int'($urandom % 32));
      mw = $urandom;
      aw = $urandom;
      add_row(c, mw, aw, field_result_model(c, mw, aw));
   endtask

   task automatic build_table();
      field_ctl_t c;
      word_t      mw;
      logic [1:0] op_bits;
      for (int p = 0; p < 32; p++) begin
         add_row(make_ctl(FOP_ROTATE, p, 31), 32'h1, $urandom, 32'h1 << p);  // walking one.
      end
      for (int p = 0; p < 32; p++) begin
         c  = make_ctl(FOP_ROTATE, p, int'($urandom % 32));
         mw = $urandom;
         add_row(c, mw, $urandom, field_result_model(c, mw, 32'h0));
      end
      add_row(make_ctl(FOP_LDB, 31, 0), 32'h8000_0000, 32'hffff_ffff, 32'h0000_0001);
      add_row(make_ctl(FOP_LDB, 31, 0), 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000);
      add_row(make_ctl(FOP_LDB, 0, 31), 32'hdead_beef, 32'h0000_0000, 32'hdead_beef);
      add_row(make_ctl(FOP_LDB, 8, 7), 32'h1234_5678, 32'hffff_ffff, 32'h0000_0056);
      repeat (16) add_random_row(FOP_LDB);
      add_row(make_ctl(FOP_DPB, 28, 7), 32'h0000_00ab, 32'hffff_ffff, 32'hbfff_ffff);
      add_row(make_ctl(FOP_DPB, 4, 7), 32'h0000_005a, 32'h0000_0000, 32'h0000_05a0);
      add_row(make_ctl(FOP_DPB, 0, 31), 32'h1357_9bdf, 32'hffff_0000, 32'h1357_9bdf);
      add_row(make_ctl(FOP_DPB, 31, 31), 32'h0000_0001, 32'h0000_0000, 32'h8000_0000);
      repeat (16) add_random_row(FOP_DPB);
      repeat (16) begin
         op_bits = 2'($urandom % 3);
         add_random_row(field_op_e'(op_bits));
      end
   endtask

   // **************************************************
   // checks
   // **************************************************

   task automatic check_word(input string name, input word_t got, input word_t want);
      n_checks++;
      if (got !== want) begin
         n_errors++;
         $display("[FAIL] %0d ns %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      n_checks++;
      if (got !== want) begin
         n_errors++;
         $display("[FAIL] %0d ns %s got %b expected %b", $time, name, got, want);
      end
   endtask

   // **************************************************
   // sequences
   // **************************************************

   // load, start, then check one cycle after the start.
   task automatic apply_row(input row_t r);
      @(posedge clk);
      ctl_load <= 1'b1;
      ctl      <= r.ctl;
      @(posedge clk);
      ctl_load <= 1'b0;
      start    <= 1'b1;
      m        <= r.m;
      a        <= r.a;
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b0);   // idle cycle.
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b1);
      check_word("result", result, r.want);
   endtask

   task automatic check_load_during_start();
      @(posedge clk);
      ctl_load <= 1'b1;
      ctl      <= make_ctl(FOP_ROTATE, 4, 31);
      @(posedge clk);
      ctl      <= make_ctl(FOP_LDB, 8, 7);           // new control with the start.
      start    <= 1'b1;
      m        <= 32'hcafe_f00d;
      a        <= $urandom;
      @(posedge clk);
      ctl_load <= 1'b0;
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b1);
      check_word("result", result, 32'hafef_00dc);    // still the old rotate.
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b1);
      check_word("result", result, 32'h0000_00f0);
   endtask

   task automatic check_back_to_back();
      field_ctl_t c1;
      field_ctl_t c2;
      field_ctl_t cur;
      word_t      mw;
      word_t      aw;
      word_t      want_q[$];
      c1 = make_ctl(FOP_DPB, 12, 7);
      c2 = make_ctl(FOP_LDB, 20, 9);
      @(posedge clk);
      ctl_load <= 1'b1;
      ctl      <= c1;
      @(posedge clk);
      ctl_load <= 1'b0;
      for (int i = 0; i <= 8; i++) begin
         @(posedge clk);
         ctl_load <= (i == 4);                      // reload mid-stream.
         ctl      <= c2;
         if (i < 8) begin
            cur   = (i >= 5) ? c2 : c1;
            mw    = $urandom;
            aw    = $urandom;
            start <= 1'b1;
            m     <= mw;
            a     <= aw;
            want_q.push_back(field_result_model(cur, mw, aw));
         end else begin
            start <= 1'b0;
         end
         if (i > 0) begin
            @(negedge clk);
            check_bit("result_valid", result_valid, 1'b1);
            check_word("result", result, want_q.pop_front());
         end
      end
      repeat (3) begin
         @(negedge clk);
         check_bit("result_valid", result_valid, 1'b0);
      end
   endtask

   // **************************************************
   // main sequence and watchdog
   // **************************************************

   initial begin
      rst_n    = 1'b0;
      ctl_load = 1'b0;
      ctl      = '0;
      start    = 1'b0;
      m        = '0;
      a        = '0;
      void'($urandom(SEED));
      build_table();
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b0);
      check_word("result", result, 32'h0);
      @(posedge clk);
      start <= 1'b1;                                // reset control, rotate by 0.
      m     <= 32'ha5c3_0f96;
      a     <= $urandom;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b1);
      check_word("result", result, 32'ha5c3_0f96);
      for (int i = 0; i < n_rows; i++) begin
         apply_row(rows[i]);
      end
      check_load_during_start();
      check_back_to_back();
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule
